/* flist.f */
source/mips_pkg.sv
source/pipeline_registers.sv
source/fetch_unit.sv
source/decode_unit.sv
source/reg_file.sv
source/hazard_unit.sv
source/execute_unit.sv
source/mips_core.sv
testbench/mips_core_assertions.sv
testbench/mips_core_tb.sv

/* testbench/mips_core_tb.sv */
`timescale 1ns/1ps

module mips_core_tb;

  import mips_pkg::*;

  localparam word_t RESET_PC    = 32'h0000_0040;
  localparam word_t SENTINEL    = 32'h0000_0ffc;
  localparam int    RUN_LIMIT   = 64 * 4;  // Cycles allowed for one program
  localparam int    NUM_RUNS    = 7;
  localparam int    WATCHDOG_NS = NUM_RUNS * 64 * 4 * 100;

  logic  clk;
  logic  arst_n;
  word_t imem_addr, imem_data, dmem_addr, dmem_wdata, dmem_rdata;
  logic  dmem_we;

  word_t       imem [64];
  word_t       dmem [word_t];
  int          emit_index;
  int unsigned mem_version;
  bit          sentinel_seen;
  integer      seed = 32'h71d7_5684;

  mips_core #(.RESET_PC(RESET_PC)) UUT (
    .clk, .arst_n, .imem_addr, .imem_data, .dmem_addr, .dmem_wdata, .dmem_we, .dmem_rdata
  );

  bind mips_core mips_core_assertions u_assertions (
    .clk, .arst_n, .dmem_we, .imem_addr, .stall, .flush, .branch_taken,
    .ex_reg_write, .ex_mem_op
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    report_failure("watchdog expired before all tests finished");
  end

  function automatic word_t read_word(input word_t addr);
    if (dmem.exists(addr)) begin
      return dmem[addr];
    end
    return ~addr;  // Unwritten words read as the inverted address
  endfunction

  function automatic word_t fetch_word(input word_t addr);
    word_t index;
    index = (addr - RESET_PC) >> 2;  // Addresses below the program wrap out of range
    return (index < 64) ? imem[index] : '0;
  endfunction

  // Both memories answer in the same cycle
  always @(imem_addr or mem_version) imem_data = fetch_word(imem_addr);
  always @(dmem_addr or mem_version) dmem_rdata = read_word(dmem_addr);

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_addr] = dmem_wdata;
      mem_version++;
      if (dmem_addr == SENTINEL) sentinel_seen = 1'b1;
    end
  end

  function automatic word_t r_type(input funct_t funct, input reg_addr_t rd, input reg_addr_t rs,
                                   input reg_addr_t rt, input shamt_t shamt);
    return {OP_RTYPE, rs, rt, rd, shamt, funct};
  endfunction

  function automatic word_t i_type(input opcode_t op, input reg_addr_t rt, input reg_addr_t rs,
                                   input imm_t imm);
    return {op, rs, rt, imm};
  endfunction

  task automatic report_failure(input string reason);
    $display("%s", reason);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string what, input word_t actual, input word_t expected);
    if (actual !== expected) begin
      $display("error at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      report_failure("a checked value did not match");
    end
  endtask

  task automatic clear_program();
    for (int i = 0; i < 64; i++) begin
      imem[i] = '0;  // All-zero words run as no-ops
    end
    emit_index = 0;
    dmem.delete();
  endtask

  task automatic emit(input word_t instruction);
    imem[emit_index] = instruction;
    emit_index++;
  endtask

  task automatic apply_reset();
    arst_n = 1'b0;
    repeat (4) begin
      @(negedge clk);
      check_value("dmem_we during reset", word_t'(dmem_we), 32'd0);
    end
    check_value("imem_addr after reset", imem_addr, RESET_PC);
    sentinel_seen = 1'b0;
    arst_n = 1'b1;
  endtask

  task automatic run_program();
    int cycles;
    emit(i_type(OP_SW, 0, 0, SENTINEL[15:0]));
    mem_version++;
    apply_reset();
    cycles = 0;
    while (!sentinel_seen && cycles < RUN_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!sentinel_seen) report_failure("program never reached its final store");
  endtask

  task automatic test_reset_state();
    clear_program();
    run_program();
    check_value("final store after reset", read_word(SENTINEL), 32'd0);
  endtask

  task automatic test_alu_forwarding();
    word_t a;
    word_t b;
    word_t expected [10];
    a = 32'd37;
    b = 32'hffff_fffb;
    expected[3] = a + b;
    expected[4] = expected[3] - a;
    expected[5] = expected[4] & a;
    expected[6] = expected[5] | expected[3];
    expected[7] = ($signed(b) < $signed(a)) ? 32'd1 : 32'd0;
    expected[8] = expected[7] << 4;
    expected[9] = expected[8];  // Register 0 must still read zero
    clear_program();
    emit(i_type(OP_ADDI, 1, 0, 16'd37));
    emit(i_type(OP_ADDI, 2, 0, 16'hfffb));
    emit(r_type(FN_ADD, 3, 1, 2, 0));
    emit(r_type(FN_SUB, 4, 3, 1, 0));
    emit(r_type(FN_AND, 5, 4, 1, 0));
    emit(r_type(FN_OR, 6, 5, 3, 0));
    emit(r_type(FN_SLT, 7, 2, 1, 0));
    emit(r_type(FN_SLL, 8, 0, 7, 4));
    emit(i_type(OP_ADDI, 0, 0, 16'd99));
    emit(r_type(FN_ADD, 9, 0, 8, 0));
    for (int r = 3; r <= 9; r++) begin
      emit(i_type(OP_SW, r, 0, 16'h0100 + 16'(4 * r)));
    end
    run_program();
    for (int r = 3; r <= 9; r++) begin
      check_value($sformatf("result of register %0d", r), read_word(32'h100 + 4 * r),
                  expected[r]);
    end
  endtask

  task automatic test_load_use(input bit with_gap);
    word_t loaded;
    loaded = 32'h1357_9bdf;
    clear_program();
    dmem[32'h200] = loaded;
    emit(i_type(OP_ADDI, 1, 0, 16'h0055));
    emit(i_type(OP_LW, 2, 0, 16'h0200));
    if (with_gap) begin
      emit(i_type(OP_ADDI, 5, 0, 16'd7));
    end
    emit(r_type(FN_ADD, 3, 2, 1, 0));
    emit(i_type(OP_SW, 3, 0, 16'h0204));
    run_program();
    check_value("sum after load", read_word(32'h204), loaded + 32'h55);
  endtask

  // Three marker stores follow the branch and a fourth store sits at its target
  task automatic run_branch(input opcode_t op, input imm_t imm_a, input imm_t imm_b,
                            input word_t base);
    word_t value_a;
    word_t value_b;
    bit    taken;
    value_a = {{16{imm_a[15]}}, imm_a};
    value_b = {{16{imm_b[15]}}, imm_b};
    taken = (op == OP_BEQ) ? (value_a == value_b) : (value_a != value_b);
    clear_program();
    emit(i_type(OP_ADDI, 1, 0, imm_a));
    emit(i_type(OP_ADDI, 2, 0, imm_b));
    emit(i_type(op, 2, 1, 16'd3));
    for (int i = 0; i < 3; i++) begin
      emit(i_type(OP_SW, 1, 0, base[15:0] + 16'(4 * i)));
    end
    emit(i_type(OP_SW, 2, 0, base[15:0] + 16'd12));
    run_program();
    for (int i = 0; i < 3; i++) begin
      check_value("marker store present", word_t'(dmem.exists(base + 4 * i)),
                  taken ? 32'd0 : 32'd1);
      if (!taken) begin
        check_value("marker store value", read_word(base + 4 * i), value_a);
      end
    end
    check_value("branch target store", read_word(base + 12), value_b);
  endtask

  task automatic test_bne(input bit same_operands);
    imm_t imm_a;
    imm_t imm_b;
    imm_a = imm_t'($random(seed));
    imm_b = same_operands ? imm_a : imm_t'($random(seed));
    run_branch(OP_BNE, imm_a, imm_b, 32'h400);
  endtask

  initial begin
    arst_n        = 1'b0;
    imem_data     = '0;
    dmem_rdata    = '0;
    mem_version   = 0;
    sentinel_seen = 1'b0;
    emit_index    = 0;
    test_reset_state();
    test_alu_forwarding();
    test_load_use(1'b0);
    test_load_use(1'b1);
    run_branch(OP_BEQ, 16'd9, 16'd9, 32'h300);
    test_bne(1'b1);
    test_bne(1'b0);
    $display("test passed");
    $finish;
  end

endmodule

/* testbench/mips_core_assertions.sv */
`timescale 1ns/1ps

module mips_core_assertions (
  input logic                clk,
  input logic                arst_n,
  input logic                dmem_we,
  input mips_pkg::word_t     imem_addr,
  input logic                stall,
  input logic                flush,
  input logic                branch_taken,
  input logic                ex_reg_write,
  input mips_pkg::mem_op_t   ex_mem_op
);

  import mips_pkg::*;

  dmem_we_known: assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(dmem_we))
    else $error("dmem_we is unknown");

  // A load-use stall freezes the fetch address unless a branch redirects it
  pc_holds_on_stall: assert property (@(posedge clk) disable iff (!arst_n)
    stall && !branch_taken |=> $stable(imem_addr))
    else $error("imem_addr moved during a stall");

  bubble_after_hold: assert property (@(posedge clk) disable iff (!arst_n)
    stall || flush |=> !ex_reg_write && ex_mem_op == MEM_NONE)
    else $error("id_ex does not hold a bubble after stall or flush");

endmodule

/* source/mips_core.sv */
`timescale 1ns/1ps

module mips_core #(
  parameter mips_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic            clk,
  input  logic            arst_n,
  output mips_pkg::word_t imem_addr,
  input  mips_pkg::word_t imem_data,
  output mips_pkg::word_t dmem_addr,
  output mips_pkg::word_t dmem_wdata,
  output logic            dmem_we,
  input  mips_pkg::word_t dmem_rdata
);

  import mips_pkg::*;

  word_t     if_pc_plus4, id_instruction, id_pc_plus4, id_immediate, id_address;
  word_t     id_read_data_1, id_read_data_2;
  reg_addr_t id_rs, id_rt, id_rd;
  shamt_t    id_shamt;
  alu_op_t   id_alu_op;
  mem_op_t   id_mem_op;
  logic      id_reg_dst, id_mem_to_reg, id_alu_src, id_reg_write, id_beq, id_bne;

  word_t     ex_read_data_1, ex_read_data_2, ex_immediate, ex_address;
  word_t     ex_alu_result, ex_store_data;
  reg_addr_t ex_rs, ex_rt, ex_rd, ex_dest;
  shamt_t    ex_shamt;
  alu_op_t   ex_alu_op;
  mem_op_t   ex_mem_op;
  logic      ex_reg_dst, ex_mem_to_reg, ex_alu_src, ex_reg_write, ex_beq, ex_bne;
  logic      ex_compare;

  word_t     mem_alu_result, mem_address;
  reg_addr_t mem_dest;
  mem_op_t   mem_mem_op;
  logic      mem_beq, mem_bne, mem_mem_to_reg, mem_reg_write, mem_compare;

  word_t     wb_ram_data, wb_alu_result, wb_result;
  reg_addr_t wb_dest;
  logic      wb_mem_to_reg, wb_reg_write;

  logic      stall, flush, branch_taken;
  fwd_sel_t  fwd_a, fwd_b;

  assign dmem_addr = mem_alu_result;
  assign dmem_we   = mem_mem_op[1];  // Store bit of the one-hot memory op

  fetch_unit #(.RESET_PC(RESET_PC)) u_fetch (
    .clk, .arst_n, .stall, .branch_taken, .branch_target(mem_address),
    .pc(imem_addr), .pc_plus4(if_pc_plus4)
  );

  if_id_register u_if_id (
    .clk, .arst_n, .stall, .flush,
    .instruction_in(imem_data), .pc_plus4_in(if_pc_plus4),
    .instruction_out(id_instruction), .pc_plus4_out(id_pc_plus4)
  );

  decode_unit u_decode (
    .instruction(id_instruction), .rs(id_rs), .rt(id_rt), .rd(id_rd), .shamt(id_shamt),
    .immediate(id_immediate), .reg_dst(id_reg_dst), .mem_to_reg(id_mem_to_reg),
    .alu_op(id_alu_op), .mem_op(id_mem_op), .alu_src(id_alu_src),
    .reg_write(id_reg_write), .beq(id_beq), .bne(id_bne),
    .pc_plus4(id_pc_plus4), .address(id_address)
  );

  reg_file u_reg_file (
    .clk, .arst_n, .rs(id_rs), .rt(id_rt),
    .read_data_1(id_read_data_1), .read_data_2(id_read_data_2),
    .wb_reg_write, .wb_mem_to_reg, .wb_dest, .wb_ram_data, .wb_alu_result, .wb_result
  );

  id_ex_register u_id_ex (
    .clk, .arst_n, .stall, .flush,
    .rs_in(id_rs), .rt_in(id_rt), .rd_in(id_rd),
    .reg_read_data_1_in(id_read_data_1), .reg_read_data_2_in(id_read_data_2),
    .immediate_in(id_immediate), .address_in(id_address), .shamt_in(id_shamt),
    .reg_dst_in(id_reg_dst), .mem_to_reg_in(id_mem_to_reg), .alu_op_in(id_alu_op),
    .mem_op_in(id_mem_op), .alu_src_in(id_alu_src), .reg_write_in(id_reg_write),
    .beq_in(id_beq), .bne_in(id_bne),
    .rs_out(ex_rs), .rt_out(ex_rt), .rd_out(ex_rd),
    .reg_read_data_1_out(ex_read_data_1), .reg_read_data_2_out(ex_read_data_2),
    .immediate_out(ex_immediate), .address_out(ex_address), .shamt_out(ex_shamt),
    .reg_dst_out(ex_reg_dst), .mem_to_reg_out(ex_mem_to_reg), .alu_op_out(ex_alu_op),
    .mem_op_out(ex_mem_op), .alu_src_out(ex_alu_src), .reg_write_out(ex_reg_write),
    .beq_out(ex_beq), .bne_out(ex_bne)
  );

  execute_unit u_execute (
    .rt(ex_rt), .rd(ex_rd), .reg_read_data_1(ex_read_data_1),
    .reg_read_data_2(ex_read_data_2), .immediate(ex_immediate), .shamt(ex_shamt),
    .reg_dst(ex_reg_dst), .alu_op(ex_alu_op), .alu_src(ex_alu_src),
    .fwd_a, .fwd_b, .mem_alu_result, .wb_result,
    .alu_result(ex_alu_result), .store_data(ex_store_data),
    .reg_dst_result(ex_dest), .compare(ex_compare)
  );

  ex_mem_register u_ex_mem (
    .clk, .arst_n, .flush,
    .alu_result_in(ex_alu_result), .data_2_in(ex_store_data), .reg_dst_result_in(ex_dest),
    .beq_in(ex_beq), .bne_in(ex_bne), .mem_op_in(ex_mem_op), .mem_to_reg_in(ex_mem_to_reg),
    .reg_write_in(ex_reg_write), .compare_in(ex_compare), .address_in(ex_address),
    .alu_result_out(mem_alu_result), .data_2_out(dmem_wdata), .reg_dst_result_out(mem_dest),
    .beq_out(mem_beq), .bne_out(mem_bne), .mem_op_out(mem_mem_op),
    .mem_to_reg_out(mem_mem_to_reg), .reg_write_out(mem_reg_write),
    .compare_out(mem_compare), .address_out(mem_address)
  );

  mem_wb_register u_mem_wb (
    .clk, .arst_n,
    .mem_to_reg_in(mem_mem_to_reg), .ram_read_data_in(dmem_rdata),
    .alu_result_in(mem_alu_result), .reg_dst_result_in(mem_dest),
    .reg_write_in(mem_reg_write),
    .mem_to_reg_out(wb_mem_to_reg), .ram_read_data_out(wb_ram_data),
    .alu_result_out(wb_alu_result), .reg_dst_result_out(wb_dest),
    .reg_write_out(wb_reg_write)
  );

  hazard_unit u_hazard (
    .id_rs, .id_rt, .ex_rs, .ex_rt, .ex_dest, .mem_dest, .wb_dest,
    .ex_is_load(ex_mem_op[0]), .mem_reg_write, .wb_reg_write,
    .mem_beq, .mem_bne, .mem_compare,
    .stall, .flush, .branch_taken, .fwd_a, .fwd_b
  );

endmodule

/* source/execute_unit.sv */
`timescale 1ns/1ps

module execute_unit (
  input  mips_pkg::reg_addr_t rt,
  input  mips_pkg::reg_addr_t rd,
  input  mips_pkg::word_t     reg_read_data_1,
  input  mips_pkg::word_t     reg_read_data_2,
  input  mips_pkg::word_t     immediate,
  input  mips_pkg::shamt_t    shamt,
  input  logic                reg_dst,
  input  mips_pkg::alu_op_t   alu_op,
  input  logic                alu_src,
  input  mips_pkg::fwd_sel_t  fwd_a,
  input  mips_pkg::fwd_sel_t  fwd_b,
  input  mips_pkg::word_t     mem_alu_result,
  input  mips_pkg::word_t     wb_result,
  output mips_pkg::word_t     alu_result,
  output mips_pkg::word_t     store_data,
  output mips_pkg::reg_addr_t reg_dst_result,
  output logic                compare
);

  import mips_pkg::*;

  word_t operand_a;
  word_t operand_b;
  word_t alu_b;

  function automatic word_t forward(input fwd_sel_t sel, input word_t reg_value,
                                    input word_t mem_value, input word_t wb_value);
    case (sel)
      FWD_MEM: return mem_value;
      FWD_WB:  return wb_value;
      default: return reg_value;
    endcase
  endfunction

  assign operand_a = forward(fwd_a, reg_read_data_1, mem_alu_result, wb_result);
  assign operand_b = forward(fwd_b, reg_read_data_2, mem_alu_result, wb_result);
  assign alu_b     = alu_src ? immediate : operand_b;

  assign store_data     = operand_b;
  assign compare        = (operand_a == operand_b);
  assign reg_dst_result = reg_dst ? rd : rt;

  always_comb begin
    case (alu_op)
      ALU_SUB: alu_result = operand_a - alu_b;
      ALU_AND: alu_result = operand_a & alu_b;
      ALU_OR:  alu_result = operand_a | alu_b;
      ALU_SLT: alu_result = {31'b0, $signed(operand_a) < $signed(alu_b)};
      ALU_SLL: alu_result = operand_b << shamt;  // Shifts the rt value
      default: alu_result = operand_a + alu_b;
    endcase
  end

endmodule

/* source/hazard_unit.sv */
`timescale 1ns/1ps

module hazard_unit (
  input  mips_pkg::reg_addr_t id_rs,
  input  mips_pkg::reg_addr_t id_rt,
  input  mips_pkg::reg_addr_t ex_rs,
  input  mips_pkg::reg_addr_t ex_rt,
  input  mips_pkg::reg_addr_t ex_dest,
  input  mips_pkg::reg_addr_t mem_dest,
  input  mips_pkg::reg_addr_t wb_dest,
  input  logic                ex_is_load,
  input  logic                mem_reg_write,
  input  logic                wb_reg_write,
  input  logic                mem_beq,
  input  logic                mem_bne,
  input  logic                mem_compare,
  output logic                stall,
  output logic                flush,
  output logic                branch_taken,
  output mips_pkg::fwd_sel_t  fwd_a,
  output mips_pkg::fwd_sel_t  fwd_b
);

  import mips_pkg::*;

  // The memory stage holds the younger result, so it is checked first
  function automatic fwd_sel_t select_source(input reg_addr_t src);
    if (src == '0) begin
      return FWD_REG;
    end else if (mem_reg_write && mem_dest == src) begin
      return FWD_MEM;
    end else if (wb_reg_write && wb_dest == src) begin
      return FWD_WB;
    end
    return FWD_REG;
  endfunction

  always_comb begin
    fwd_a = select_source(ex_rs);
    fwd_b = select_source(ex_rt);
  end

  assign stall = ex_is_load && (ex_dest != '0) && (ex_dest == id_rs || ex_dest == id_rt);

  assign branch_taken = (mem_beq && mem_compare) || (mem_bne && !mem_compare);
  assign flush        = branch_taken;  // Drops the three instructions behind the branch

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
  input  logic                clk,
  input  logic                arst_n,
  input  mips_pkg::reg_addr_t rs,
  input  mips_pkg::reg_addr_t rt,
  output mips_pkg::word_t     read_data_1,
  output mips_pkg::word_t     read_data_2,
  input  logic                wb_reg_write,
  input  logic                wb_mem_to_reg,
  input  mips_pkg::reg_addr_t wb_dest,
  input  mips_pkg::word_t     wb_ram_data,
  input  mips_pkg::word_t     wb_alu_result,
  output mips_pkg::word_t     wb_result
);

  import mips_pkg::*;

  word_t regs [32];
  logic  wb_active;

  assign wb_result = wb_mem_to_reg ? wb_ram_data : wb_alu_result;
  assign wb_active = wb_reg_write && (wb_dest != '0);  // Register 0 stays zero from reset

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_active) begin
      regs[wb_dest] <= wb_result;
    end
  end

  // The value being written this cycle is passed straight to decode
  always_comb begin
    read_data_1 = (wb_active && wb_dest == rs) ? wb_result : regs[rs];
    read_data_2 = (wb_active && wb_dest == rt) ? wb_result : regs[rt];
  end

endmodule

/* source/decode_unit.sv */
`timescale 1ns/1ps

module decode_unit (
  input  mips_pkg::word_t     instruction,
  output mips_pkg::reg_addr_t rs,
  output mips_pkg::reg_addr_t rt,
  output mips_pkg::reg_addr_t rd,
  output mips_pkg::shamt_t    shamt,
  output mips_pkg::word_t     immediate,
  output logic                reg_dst,
  output logic                mem_to_reg,
  output mips_pkg::alu_op_t   alu_op,
  output mips_pkg::mem_op_t   mem_op,
  output logic                alu_src,
  output logic                reg_write,
  output logic                beq,
  output logic                bne,
  input  mips_pkg::word_t     pc_plus4,
  output mips_pkg::word_t     address
);

  import mips_pkg::*;

  opcode_t opcode;
  funct_t  funct;
  imm_t    imm;

  assign opcode = instruction[31:26];
  assign rs     = instruction[25:21];
  assign rt     = instruction[20:16];
  assign rd     = instruction[15:11];
  assign shamt  = instruction[10:6];
  assign funct  = instruction[5:0];
  assign imm    = instruction[15:0];

  assign immediate = {{16{imm[15]}}, imm};
  assign address   = pc_plus4 + {immediate[29:0], 2'b00};  // Word offset from the next pc

  always_comb begin
    reg_dst    = 1'b0;
    mem_to_reg = 1'b0;
    alu_op     = ALU_ADD;
    mem_op     = MEM_NONE;
    alu_src    = 1'b0;
    reg_write  = 1'b0;
    beq        = 1'b0;
    bne        = 1'b0;
    case (opcode)
      OP_RTYPE: begin
        reg_dst   = 1'b1;
        reg_write = 1'b1;
        case (funct)
          FN_ADD:  alu_op = ALU_ADD;
          FN_SUB:  alu_op = ALU_SUB;
          FN_AND:  alu_op = ALU_AND;
          FN_OR:   alu_op = ALU_OR;
          FN_SLT:  alu_op = ALU_SLT;
          FN_SLL:  alu_op = ALU_SLL;
          default: reg_write = 1'b0;
        endcase
      end
      OP_ADDI: begin
        alu_src   = 1'b1;
        reg_write = 1'b1;
      end
      OP_LW: begin
        alu_src    = 1'b1;
        reg_write  = 1'b1;
        mem_to_reg = 1'b1;
        mem_op     = MEM_LOAD;
      end
      OP_SW: begin
        alu_src = 1'b1;
        mem_op  = MEM_STORE;
      end
      OP_BEQ:  beq = 1'b1;
      OP_BNE:  bne = 1'b1;
      default: ;  // Anything else runs as a no-op
    endcase
  end

endmodule

/* source/fetch_unit.sv */
`timescale 1ns/1ps

module fetch_unit #(
  parameter mips_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            stall,
  input  logic            branch_taken,
  input  mips_pkg::word_t branch_target,
  output mips_pkg::word_t pc,
  output mips_pkg::word_t pc_plus4
);

  assign pc_plus4 = pc + 32'd4;

  // A resolved branch has priority, since the stalled instruction is being flushed
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc <= RESET_PC;
    end else if (branch_taken) begin
      pc <= branch_target;
    end else if (!stall) begin
      pc <= pc_plus4;
    end
  end

endmodule

/* source/pipeline_registers.sv */
`timescale 1ns/1ps

module if_id_register (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            stall,
  input  logic            flush,
  input  mips_pkg::word_t instruction_in,
  input  mips_pkg::word_t pc_plus4_in,
  output mips_pkg::word_t instruction_out,
  output mips_pkg::word_t pc_plus4_out
);

  // An all-zero word is sll $0, $0, 0 and has no effect
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      {instruction_out, pc_plus4_out} <= '0;
    end else if (flush) begin
      {instruction_out, pc_plus4_out} <= '0;
    end else if (!stall) begin
      {instruction_out, pc_plus4_out} <= {instruction_in, pc_plus4_in};
    end
  end

endmodule

module id_ex_register (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                stall,
  input  logic                flush,
  input  mips_pkg::reg_addr_t rs_in, rt_in, rd_in,
  input  mips_pkg::word_t     reg_read_data_1_in, reg_read_data_2_in,
  input  mips_pkg::word_t     immediate_in, address_in,
  input  mips_pkg::shamt_t    shamt_in,
  input  logic                reg_dst_in, mem_to_reg_in,
  input  mips_pkg::alu_op_t   alu_op_in,
  input  mips_pkg::mem_op_t   mem_op_in,
  input  logic                alu_src_in, reg_write_in, beq_in, bne_in,
  output mips_pkg::reg_addr_t rs_out, rt_out, rd_out,
  output mips_pkg::word_t     reg_read_data_1_out, reg_read_data_2_out,
  output mips_pkg::word_t     immediate_out, address_out,
  output mips_pkg::shamt_t    shamt_out,
  output logic                reg_dst_out, mem_to_reg_out,
  output mips_pkg::alu_op_t   alu_op_out,
  output mips_pkg::mem_op_t   mem_op_out,
  output logic                alu_src_out, reg_write_out, beq_out, bne_out
);

  // A stall leaves the decode instruction in place and sends a bubble on
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      {rs_out, rt_out, rd_out, reg_read_data_1_out, reg_read_data_2_out, immediate_out,
       address_out, shamt_out, reg_dst_out, mem_to_reg_out, alu_op_out, mem_op_out,
       alu_src_out, reg_write_out, beq_out, bne_out} <= '0;
    end else if (flush || stall) begin
      {rs_out, rt_out, rd_out, reg_read_data_1_out, reg_read_data_2_out, immediate_out,
       address_out, shamt_out, reg_dst_out, mem_to_reg_out, alu_op_out, mem_op_out,
       alu_src_out, reg_write_out, beq_out, bne_out} <= '0;
    end else begin
      {rs_out, rt_out, rd_out, reg_read_data_1_out, reg_read_data_2_out, immediate_out,
       address_out, shamt_out, reg_dst_out, mem_to_reg_out, alu_op_out, mem_op_out,
       alu_src_out, reg_write_out, beq_out, bne_out} <=
      {rs_in, rt_in, rd_in, reg_read_data_1_in, reg_read_data_2_in, immediate_in,
       address_in, shamt_in, reg_dst_in, mem_to_reg_in, alu_op_in, mem_op_in,
       alu_src_in, reg_write_in, beq_in, bne_in};
    end
  end

endmodule

module ex_mem_register (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                flush,
  input  mips_pkg::word_t     alu_result_in, data_2_in,
  input  mips_pkg::reg_addr_t reg_dst_result_in,
  input  logic                beq_in, bne_in,
  input  mips_pkg::mem_op_t   mem_op_in,
  input  logic                mem_to_reg_in, reg_write_in, compare_in,
  input  mips_pkg::word_t     address_in,
  output mips_pkg::word_t     alu_result_out, data_2_out,
  output mips_pkg::reg_addr_t reg_dst_result_out,
  output logic                beq_out, bne_out,
  output mips_pkg::mem_op_t   mem_op_out,
  output logic                mem_to_reg_out, reg_write_out, compare_out,
  output mips_pkg::word_t     address_out
);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      {alu_result_out, data_2_out, reg_dst_result_out, beq_out, bne_out, mem_op_out,
       mem_to_reg_out, reg_write_out, compare_out, address_out} <= '0;
    end else if (flush) begin
      {alu_result_out, data_2_out, reg_dst_result_out, beq_out, bne_out, mem_op_out,
       mem_to_reg_out, reg_write_out, compare_out, address_out} <= '0;
    end else begin
      {alu_result_out, data_2_out, reg_dst_result_out, beq_out, bne_out, mem_op_out,
       mem_to_reg_out, reg_write_out, compare_out, address_out} <=
      {alu_result_in, data_2_in, reg_dst_result_in, beq_in, bne_in, mem_op_in,
       mem_to_reg_in, reg_write_in, compare_in, address_in};
    end
  end

endmodule

module mem_wb_register (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                mem_to_reg_in,
  input  mips_pkg::word_t     ram_read_data_in, alu_result_in,
  input  mips_pkg::reg_addr_t reg_dst_result_in,
  input  logic                reg_write_in,
  output logic                mem_to_reg_out,
  output mips_pkg::word_t     ram_read_data_out, alu_result_out,
  output mips_pkg::reg_addr_t reg_dst_result_out,
  output logic                reg_write_out
);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      {mem_to_reg_out, ram_read_data_out, alu_result_out, reg_dst_result_out,
       reg_write_out} <= '0;
    end else begin
      {mem_to_reg_out, ram_read_data_out, alu_result_out, reg_dst_result_out,
       reg_write_out} <=
      {mem_to_reg_in, ram_read_data_in, alu_result_in, reg_dst_result_in, reg_write_in};
    end
  end

endmodule

/* source/mips_pkg.sv */
package mips_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [15:0] imm_t;
  typedef logic [4:0]  shamt_t;
  typedef logic [5:0]  opcode_t;
  typedef logic [5:0]  funct_t;
  typedef logic [2:0]  alu_op_t;
  typedef logic [1:0]  mem_op_t;
  typedef logic [1:0]  fwd_sel_t;

  localparam opcode_t OP_RTYPE = 6'h00;
  localparam opcode_t OP_ADDI  = 6'h08;
  localparam opcode_t OP_LW    = 6'h23;
  localparam opcode_t OP_SW    = 6'h2b;
  localparam opcode_t OP_BEQ   = 6'h04;
  localparam opcode_t OP_BNE   = 6'h05;

  localparam funct_t FN_ADD = 6'h20;
  localparam funct_t FN_SUB = 6'h22;
  localparam funct_t FN_AND = 6'h24;
  localparam funct_t FN_OR  = 6'h25;
  localparam funct_t FN_SLT = 6'h2a;
  localparam funct_t FN_SLL = 6'h00;

  localparam alu_op_t ALU_ADD = 3'd0;  // Zero so that a bubble adds
  localparam alu_op_t ALU_SUB = 3'd1;
  localparam alu_op_t ALU_AND = 3'd2;
  localparam alu_op_t ALU_OR  = 3'd3;
  localparam alu_op_t ALU_SLT = 3'd4;
  localparam alu_op_t ALU_SLL = 3'd5;

  // One-hot, bit 0 marks a load and bit 1 a store
  localparam mem_op_t MEM_NONE  = 2'b00;
  localparam mem_op_t MEM_LOAD  = 2'b01;
  localparam mem_op_t MEM_STORE = 2'b10;

  localparam fwd_sel_t FWD_REG = 2'd0;
  localparam fwd_sel_t FWD_MEM = 2'd1;
  localparam fwd_sel_t FWD_WB  = 2'd2;

endpackage
